// ==== Bender.yml ====
package:
  name: cdi_host

sources:
  - include_dirs:
      - include
    files:
      - hdl/cdi_host_pkg.sv
      - hdl/rom_download.sv
      - hdl/worm_loader.sv
      - hdl/nvram_sync.sv
      - hdl/cdi_host_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_cdi_host.sv

// ==== hdl/cdi_host_pkg.sv ====
`include "cdi_host_cfg.svh"

package cdi_host_pkg;

    typedef logic [`CDI_DL_ADDR_W-1:0] dl_addr_t;
    typedef logic [`CDI_DL_DATA_W-1:0] dl_word_t;
    typedef logic [`CDI_SDRAM_ADR_W-1:0] sdram_adr_t;
    typedef logic [`CDI_NVRAM_ADR_W-1:0] nvram_adr_t;
    typedef logic [`CDI_BLK_ADR_W-1:0] blk_adr_t;
    typedef logic [7:0] byte_t;

    // One strobed word from the host download port
    typedef struct packed {
        dl_addr_t addr;
        dl_word_t data;
    } dl_beat_t;

    // Wishbone classic master request
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        sdram_adr_t adr;
        dl_word_t   dat;
        logic [1:0] sel;
    } wb_req_t;

    typedef enum logic {ROM_IDLE, ROM_WRITE} rom_state_e;

    typedef enum logic [3:0] {
        NV_IDLE, NV_WAIT_ACK,
        NV_BACKUP0, NV_BACKUP1, NV_BACKUP2, NV_BACKUP3,
        NV_RESTORE0, NV_RESTORE1, NV_RESTORE2
    } nvram_state_e;

endpackage

// ==== hdl/cdi_host_top.sv ====
`timescale 1ns/1ps

`include "cdi_host_cfg.svh"

module cdi_host_top (
    input  logic                       clk_sys,
    input  logic                       cditop_reset,
    input  cdi_host_pkg::dl_beat_t     dl_beat,
    input  logic                       dl_wr,
    input  logic [15:0]                dl_index,
    input  logic                       dl_active,
    input  logic                       sdram_ack,
    input  logic                       img_mounted,
    input  logic [63:0]                img_size,
    input  logic                       osd_open,
    input  logic                       blk_ack,
    input  cdi_host_pkg::blk_adr_t     blk_buff_addr,
    input  cdi_host_pkg::dl_word_t     blk_dout,
    input  logic                       blk_buff_wr,
    input  cdi_host_pkg::byte_t        nv_rdata,
    input  logic                       nv_cpu_changed,
    output cdi_host_pkg::wb_req_t      sdram_req,
    output logic                       rom_overflow,
    output cdi_host_pkg::nvram_adr_t   worm_adr,
    output cdi_host_pkg::byte_t        worm_data,
    output logic                       worm_wr,
    output logic                       blk_rd,
    output logic                       blk_wr,
    output cdi_host_pkg::dl_word_t     blk_din,
    output cdi_host_pkg::nvram_adr_t   nv_adr,
    output cdi_host_pkg::byte_t        nv_wdata,
    output logic                       nv_we,
    output logic                       nv_cpu_access,
    output logic                       led_backup_pending
);

    logic rom_wr;
    logic worm_load;

    // Index 0x0000 is the main boot ROM, 0x0040 the slave WORM
    assign rom_wr    = dl_wr && !dl_index[`CDI_WORM_IDX_BIT];
    assign worm_load = dl_wr && dl_index[`CDI_WORM_IDX_BIT];

    rom_download i_rom_download (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .dl_beat      (dl_beat),
        .rom_wr       (rom_wr),
        .dl_active    (dl_active),
        .sdram_ack    (sdram_ack),
        .sdram_req    (sdram_req),
        .rom_overflow (rom_overflow)
    );

    worm_loader i_worm_loader (
        .clk_sys      (clk_sys),
        .cditop_reset (cditop_reset),
        .dl_beat      (dl_beat),
        .worm_load    (worm_load),
        .worm_adr     (worm_adr),
        .worm_data    (worm_data),
        .worm_wr      (worm_wr)
    );

    nvram_sync i_nvram_sync (
        .clk_sys            (clk_sys),
        .cditop_reset       (cditop_reset),
        .img_mounted        (img_mounted),
        .img_size           (img_size),
        .osd_open           (osd_open),
        .blk_ack            (blk_ack),
        .blk_buff_addr      (blk_buff_addr),
        .blk_dout           (blk_dout),
        .blk_buff_wr        (blk_buff_wr),
        .nv_rdata           (nv_rdata),
        .nv_cpu_changed     (nv_cpu_changed),
        .blk_rd             (blk_rd),
        .blk_wr             (blk_wr),
        .blk_din            (blk_din),
        .nv_adr             (nv_adr),
        .nv_wdata           (nv_wdata),
        .nv_we              (nv_we),
        .nv_cpu_access      (nv_cpu_access),
        .led_backup_pending (led_backup_pending)
    );

endmodule

// ==== hdl/nvram_sync.sv ====
`timescale 1ns/1ps

`include "cdi_host_cfg.svh"

module nvram_sync (
    input  logic                       clk_sys,
    input  logic                       cditop_reset,
    input  logic                       img_mounted,
    input  logic [63:0]                img_size,
    input  logic                       osd_open,
    input  logic                       blk_ack,
    input  cdi_host_pkg::blk_adr_t     blk_buff_addr,
    input  cdi_host_pkg::dl_word_t     blk_dout,
    input  logic                       blk_buff_wr,
    input  cdi_host_pkg::byte_t        nv_rdata,
    input  logic                       nv_cpu_changed,
    output logic                       blk_rd,
    output logic                       blk_wr,
    output cdi_host_pkg::dl_word_t     blk_din,
    output cdi_host_pkg::nvram_adr_t   nv_adr,
    output cdi_host_pkg::byte_t        nv_wdata,
    output logic                       nv_we,
    output logic                       nv_cpu_access,
    output logic                       led_backup_pending
);

    cdi_host_pkg::nvram_state_e state;

    logic                   img_mount;
    logic                   image_present;
    logic                   osd_open_q;
    cdi_host_pkg::blk_adr_t blk_buff_addr_q;

    // Word received from the host, written out one byte at a time
    cdi_host_pkg::dl_word_t restore_word;

    // Only a non-empty image counts as a mount
    assign img_mount = img_mounted && (img_size != 64'd0);

    // Even address takes the low byte
    assign nv_wdata = nv_adr[0] ? restore_word[15:8] : restore_word[7:0];

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state              <= cdi_host_pkg::NV_IDLE;
            blk_rd             <= 1'b0;
            blk_wr             <= 1'b0;
            nv_we              <= 1'b0;
            nv_adr             <= '0;
            nv_cpu_access      <= 1'b1;
            led_backup_pending <= 1'b0;
            image_present      <= 1'b0;
            osd_open_q         <= 1'b0;
            blk_buff_addr_q    <= '0;
        end else begin
            nv_we           <= 1'b0;
            osd_open_q      <= osd_open;
            blk_buff_addr_q <= blk_buff_addr;

            if (img_mounted) begin
                image_present <= (img_size != 64'd0);
            end

            // Nothing to back up to without an image
            if (nv_cpu_changed && image_present) begin
                led_backup_pending <= 1'b1;
            end

            if (blk_ack) begin
                blk_rd <= 1'b0;
                blk_wr <= 1'b0;
            end

            case (state)
                cdi_host_pkg::NV_IDLE: begin
                    nv_cpu_access <= 1'b1;
                    nv_adr        <= '0;
                    if (img_mount) begin
                        blk_rd        <= 1'b1;
                        nv_cpu_access <= 1'b0;
                        state         <= cdi_host_pkg::NV_WAIT_ACK;
                    end else if (led_backup_pending && osd_open && !osd_open_q) begin
                        // Cleared here so a later change queues another backup
                        led_backup_pending <= 1'b0;
                        blk_wr             <= 1'b1;
                        nv_cpu_access      <= 1'b0;
                        state              <= cdi_host_pkg::NV_WAIT_ACK;
                    end
                end
                cdi_host_pkg::NV_WAIT_ACK: begin
                    if (blk_ack && blk_rd) begin
                        state <= cdi_host_pkg::NV_RESTORE0;
                    end
                    if (blk_ack && blk_wr) begin
                        state <= cdi_host_pkg::NV_BACKUP0;
                    end
                end

                // ==============================
                // Backup, NvRAM to host
                // ==============================
                cdi_host_pkg::NV_BACKUP0: begin
                    // Read of byte 0 is already on its way
                    nv_adr <= nv_adr + 1'b1;
                    state  <= cdi_host_pkg::NV_BACKUP1;
                end
                cdi_host_pkg::NV_BACKUP1: begin
                    blk_din[7:0] <= nv_rdata;
                    nv_adr       <= nv_adr + 1'b1;
                    state        <= cdi_host_pkg::NV_BACKUP2;
                end
                cdi_host_pkg::NV_BACKUP2: begin
                    blk_din[15:8] <= nv_rdata;
                    state         <= cdi_host_pkg::NV_BACKUP3;
                end
                cdi_host_pkg::NV_BACKUP3: begin
                    // Host moved on, fetch the next pair
                    if (blk_buff_addr != blk_buff_addr_q) begin
                        nv_adr <= nv_adr + 1'b1;
                        state  <= cdi_host_pkg::NV_BACKUP1;
                    end
                    if (!blk_ack) begin
                        state <= cdi_host_pkg::NV_IDLE;
                    end
                end

                // ==============================
                // Restore, host to NvRAM
                // ==============================
                cdi_host_pkg::NV_RESTORE0: begin
                    if (blk_buff_wr) begin
                        restore_word <= blk_dout;
                        nv_we        <= 1'b1;
                        state        <= cdi_host_pkg::NV_RESTORE1;
                    end
                    if (!blk_ack) begin
                        nv_cpu_access <= 1'b1;
                        state         <= cdi_host_pkg::NV_IDLE;
                    end
                end
                cdi_host_pkg::NV_RESTORE1: begin
                    // Low byte written this cycle, high byte next
                    nv_we  <= 1'b1;
                    nv_adr <= nv_adr + 1'b1;
                    state  <= cdi_host_pkg::NV_RESTORE2;
                end
                cdi_host_pkg::NV_RESTORE2: begin
                    nv_adr <= nv_adr + 1'b1;
                    state  <= cdi_host_pkg::NV_RESTORE0;
                end
                default: state <= cdi_host_pkg::NV_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/rom_download.sv ====
`timescale 1ns/1ps

`include "cdi_host_cfg.svh"

module rom_download (
    input  logic                    clk_sys,
    input  logic                    cditop_reset,
    input  cdi_host_pkg::dl_beat_t  dl_beat,
    input  logic                    rom_wr,
    input  logic                    dl_active,
    input  logic                    sdram_ack,
    output cdi_host_pkg::wb_req_t   sdram_req,
    output logic                    rom_overflow
);

    cdi_host_pkg::rom_state_e state;

    // Previous download flag, for the start edge
    logic dl_active_q;

    cdi_host_pkg::sdram_adr_t rom_adr;
    cdi_host_pkg::dl_word_t   rom_dat;

    // Word address inside the ROM window, bit 0 always clear
    assign rom_adr = cdi_host_pkg::sdram_adr_t'(`CDI_ROM_BASE)
                   + cdi_host_pkg::sdram_adr_t'({dl_beat.addr[`CDI_ROM_ADDR_MSB:1], 1'b0});

    // Host words are little endian, the 68k expects big endian
    assign rom_dat = {dl_beat.data[7:0], dl_beat.data[15:8]};

    // ==============================
    // Wishbone write FSM
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            state         <= cdi_host_pkg::ROM_IDLE;
            sdram_req.cyc <= 1'b0;
            sdram_req.stb <= 1'b0;
            sdram_req.we  <= 1'b0;
        end else begin
            case (state)
                cdi_host_pkg::ROM_IDLE: begin
                    if (rom_wr) begin
                        sdram_req.cyc <= 1'b1;
                        sdram_req.stb <= 1'b1;
                        sdram_req.we  <= 1'b1;
                        state         <= cdi_host_pkg::ROM_WRITE;
                    end
                end
                cdi_host_pkg::ROM_WRITE: begin
                    // Request is held until the slave acknowledges it
                    if (sdram_ack) begin
                        sdram_req.cyc <= 1'b0;
                        sdram_req.stb <= 1'b0;
                        sdram_req.we  <= 1'b0;
                        state         <= cdi_host_pkg::ROM_IDLE;
                    end
                end
                default: state <= cdi_host_pkg::ROM_IDLE;
            endcase
        end
    end

    // Payload only changes when a new transfer is accepted
    always_ff @(posedge clk_sys) begin
        if (state == cdi_host_pkg::ROM_IDLE && rom_wr) begin
            sdram_req.adr <= rom_adr;
            sdram_req.dat <= rom_dat;
            sdram_req.sel <= 2'b11;
        end
    end

    // ==============================
    // Overflow flag
    // ==============================
    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            dl_active_q  <= 1'b0;
            rom_overflow <= 1'b0;
        end else begin
            dl_active_q <= dl_active;

            // A new download session starts clean
            if (dl_active && !dl_active_q) begin
                rom_overflow <= 1'b0;
            end

            // No back-pressure on the host side, so this beat is lost
            if (rom_wr && state == cdi_host_pkg::ROM_WRITE) begin
                rom_overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/worm_loader.sv ====
`timescale 1ns/1ps

`include "cdi_host_cfg.svh"

module worm_loader (
    input  logic                       clk_sys,
    input  logic                       cditop_reset,
    input  cdi_host_pkg::dl_beat_t     dl_beat,
    input  logic                       worm_load,
    output cdi_host_pkg::nvram_adr_t   worm_adr,
    output cdi_host_pkg::byte_t        worm_data,
    output logic                       worm_wr
);

    // Set in the cycle the low byte is presented
    logic                hi_pending;
    cdi_host_pkg::byte_t hi_byte;

    always_ff @(posedge clk_sys) begin
        if (cditop_reset) begin
            hi_pending <= 1'b0;
            worm_wr    <= 1'b0;
        end else begin
            hi_pending <= worm_load;
            worm_wr    <= worm_load || hi_pending;
        end
    end

    // Low byte goes out first, the high byte follows one cycle later
    always_ff @(posedge clk_sys) begin
        if (worm_load) begin
            worm_adr  <= {dl_beat.addr[`CDI_NVRAM_ADR_W-1:1], 1'b0};
            worm_data <= dl_beat.data[7:0];
            hi_byte   <= dl_beat.data[15:8];
        end else if (hi_pending) begin
            worm_adr[0] <= 1'b1;
            worm_data   <= hi_byte;
        end
    end

endmodule

// ==== include/cdi_host_cfg.svh ====
`ifndef CDI_HOST_CFG_SVH
`define CDI_HOST_CFG_SVH

// ==============================
// Host download port
// ==============================
`define CDI_DL_ADDR_W 25
`define CDI_DL_DATA_W 16

// Slave WORM image when this index bit is set
`define CDI_WORM_IDX_BIT 6

// ==============================
// SDRAM and ROM window
// ==============================
`define CDI_SDRAM_ADR_W 25
`define CDI_ROM_BASE 24'h400000
`define CDI_ROM_ADDR_MSB 21

// NvRAM of 8 kB, moved through a 256 word block buffer
`define CDI_NVRAM_ADR_W 13
`define CDI_BLK_ADR_W 8

`endif

// ==== sim.f ====
+incdir+include
hdl/cdi_host_pkg.sv
hdl/rom_download.sv
hdl/worm_loader.sv
hdl/nvram_sync.sv
hdl/cdi_host_top.sv
verif/tb_cdi_host.sv

// ==== verif/tb_cdi_host.sv ====
`timescale 1ns/1ps

`include "cdi_host_cfg.svh"

module tb_cdi_host;

    localparam int TIMEOUT = 200;

    typedef enum {
        K_RESET, K_ROM, K_OVERFLOW, K_WORM, K_MOUNT_EMPTY, K_RESTORE, K_BACKUP
    } test_kind_e;

    logic                     clk_sys;
    logic                     cditop_reset;
    cdi_host_pkg::dl_beat_t   dl_beat;
    logic                     dl_wr;
    logic [15:0]              dl_index;
    logic                     dl_active;
    logic                     sdram_ack;
    logic                     img_mounted;
    logic [63:0]              img_size;
    logic                     osd_open;
    logic                     blk_ack;
    cdi_host_pkg::blk_adr_t   blk_buff_addr;
    cdi_host_pkg::dl_word_t   blk_dout;
    logic                     blk_buff_wr;
    cdi_host_pkg::byte_t      nv_rdata;
    logic                     nv_cpu_changed;
    cdi_host_pkg::wb_req_t    sdram_req;
    logic                     rom_overflow;
    cdi_host_pkg::nvram_adr_t worm_adr;
    cdi_host_pkg::byte_t      worm_data;
    logic                     worm_wr;
    logic                     blk_rd;
    logic                     blk_wr;
    cdi_host_pkg::dl_word_t   blk_din;
    cdi_host_pkg::nvram_adr_t nv_adr;
    cdi_host_pkg::byte_t      nv_wdata;
    logic                     nv_we;
    logic                     nv_cpu_access;
    logic                     led_backup_pending;

    // NvRAM model behind the DUT
    cdi_host_pkg::byte_t nv_mem [0:(1 << `CDI_NVRAM_ADR_W)-1];

    // One queue per column of the test table
    string       name_q[$];
    test_kind_e  kind_q[$];
    logic [24:0] addr_q[$];
    logic [15:0] data_q[$];
    logic [40:0] exp_q[$];

    int          error_count;
    int          pass_count;
    int          fail_count;
    int unsigned rnd;

    cdi_host_top i_cdi_host_top (.*);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // Read data one cycle after the address
    always @(posedge clk_sys) begin
        nv_rdata <= #2 nv_mem[nv_adr];
        if (nv_we) begin
            nv_mem[nv_adr] = nv_wdata;
        end
    end

    // ==============================
    // Helpers
    // ==============================
    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic add_entry(input string name, input test_kind_e kind, input logic [24:0] addr,
                             input logic [15:0] data, input logic [40:0] expected);
        name_q.push_back(name);
        kind_q.push_back(kind);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(expected);
    endtask

    task automatic check_reset_state(input string name);
        check({name, " wb"}, 2'b00, {sdram_req.cyc, sdram_req.stb});
        check({name, " strobes"}, 4'h0, {worm_wr, blk_rd, blk_wr, nv_we});
        check({name, " flags"}, 2'b00, {led_backup_pending, rom_overflow});
        check({name, " cpu access"}, 1'b1, nv_cpu_access);
    endtask

    // ==============================
    // Download port
    // ==============================
    task automatic drive_beat(input logic [24:0] addr, input logic [15:0] data,
                              input logic [15:0] index);
        dl_beat.addr = addr;
        dl_beat.data = data;
        dl_index     = index;
        dl_wr        = 1'b1;
        next_cycle();
        dl_wr = 1'b0;
    endtask

    task automatic wait_rom_strobe();
        int n;
        n = 0;
        while (!sdram_req.stb) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                abort_run("No Wishbone strobe appeared after a main-ROM beat");
            end
        end
    endtask

    task automatic run_rom_beat(input string name, input logic [24:0] addr,
                                input logic [15:0] data, input logic [40:0] expected);
        int delay;
        drive_beat(addr, data, 16'h0000);
        wait_rom_strobe();
        check({name, " sel"}, 2'b11, sdram_req.sel);
        delay = $urandom % 6;
        // Request must stay put while the slave stalls
        for (int i = 0; i <= delay; i++) begin
            check({name, " adr"}, expected[40:16], sdram_req.adr);
            check({name, " dat"}, expected[15:0], sdram_req.dat);
            check({name, " held"}, 3'b111, {sdram_req.cyc, sdram_req.stb, sdram_req.we});
            if (i < delay) begin
                next_cycle();
            end
        end
        sdram_ack = 1'b1;
        next_cycle();
        sdram_ack = 1'b0;
        check({name, " release"}, 2'b00, {sdram_req.cyc, sdram_req.stb});
        check({name, " overflow"}, 1'b0, rom_overflow);
    endtask

    task automatic run_overflow(input string name, input logic [24:0] addr,
                                input logic [15:0] data, input logic [40:0] expected);
        drive_beat(addr, data, 16'h0000);
        wait_rom_strobe();
        // Second beat while the first is still unacknowledged
        drive_beat(addr + 25'd2, ~data, 16'h0000);
        check({name, " set"}, 1'b1, rom_overflow);
        check({name, " adr"}, expected[40:16], sdram_req.adr);
        check({name, " dat"}, expected[15:0], sdram_req.dat);
        sdram_ack = 1'b1;
        next_cycle();
        sdram_ack = 1'b0;
        check({name, " release"}, 1'b0, sdram_req.stb);
        next_cycle();
        check({name, " sticky"}, 1'b1, rom_overflow);
        dl_active = 1'b0;
        next_cycle();
        dl_active = 1'b1;
        next_cycle();
        check({name, " cleared"}, 1'b0, rom_overflow);
    endtask

    task automatic run_worm_beat(input string name, input logic [24:0] addr,
                                 input logic [15:0] data, input logic [40:0] expected);
        int n;
        drive_beat(addr, data, 16'h0040);
        dl_index = 16'h0000;
        n = 0;
        while (!worm_wr) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                abort_run("No WORM byte write appeared after a slave-memory beat");
            end
        end
        // Low byte is due in the cycle right after the beat
        check({name, " lo latency"}, 0, n);
        check({name, " lo adr"}, expected[40:16], worm_adr);
        check({name, " lo data"}, expected[7:0], worm_data);
        next_cycle();
        check({name, " hi wr"}, 1'b1, worm_wr);
        check({name, " hi adr"}, expected[40:16] | 25'h1, worm_adr);
        check({name, " hi data"}, expected[15:8], worm_data);
        next_cycle();
        check({name, " end"}, 1'b0, worm_wr);
    endtask

    // ==============================
    // NvRAM image sync
    // ==============================
    task automatic run_mount_empty(input string name);
        img_size    = 64'd0;
        img_mounted = 1'b1;
        next_cycle();
        img_mounted    = 1'b0;
        nv_cpu_changed = 1'b1;
        next_cycle();
        nv_cpu_changed = 1'b0;
        repeat (8) begin
            check({name, " idle"}, 3'b001, {blk_rd, led_backup_pending, nv_cpu_access});
            next_cycle();
        end
    endtask

    task automatic wait_cpu_access();
        int n;
        n = 0;
        while (!nv_cpu_access) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                abort_run("NvRAM never returned to the CPU after blk_ack fell");
            end
        end
    endtask

    task automatic run_restore(input string name, input int count, input logic [15:0] first);
        int          n;
        logic [15:0] word;
        img_size    = 64'd8192;
        img_mounted = 1'b1;
        next_cycle();
        img_mounted = 1'b0;
        n = 0;
        while (!blk_rd) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                abort_run("No block read request after mounting an image");
            end
        end
        check({name, " cpu access"}, 1'b0, nv_cpu_access);
        blk_ack = 1'b1;
        next_cycle();
        for (int k = 0; k < count; k++) begin
            blk_dout    = first + 16'(k) * 16'h0203;
            blk_buff_wr = 1'b1;
            next_cycle();
            blk_buff_wr = 1'b0;
            repeat (4) next_cycle();
        end
        check({name, " rd dropped"}, 1'b0, blk_rd);
        check({name, " cpu held off"}, 1'b0, nv_cpu_access);
        blk_ack = 1'b0;
        wait_cpu_access();
        for (int k = 0; k < count; k++) begin
            word = first + 16'(k) * 16'h0203;
            check({name, " lo byte"}, word[7:0], nv_mem[2*k]);
            check({name, " hi byte"}, word[15:8], nv_mem[2*k+1]);
        end
    endtask

    task automatic run_backup(input string name, input int count);
        int n;
        nv_cpu_changed = 1'b1;
        next_cycle();
        nv_cpu_changed = 1'b0;
        check({name, " led on"}, 1'b1, led_backup_pending);
        osd_open = 1'b1;
        next_cycle();
        n = 0;
        while (!blk_wr) begin
            next_cycle();
            n++;
            if (n > TIMEOUT) begin
                abort_run("No block write request after the menu opened");
            end
        end
        check({name, " led off"}, 1'b0, led_backup_pending);
        check({name, " cpu access"}, 1'b0, nv_cpu_access);
        blk_ack = 1'b1;
        // First word is valid 4 cycles after the acknowledge
        repeat (4) next_cycle();
        check({name, " wr dropped"}, 1'b0, blk_wr);
        for (int k = 0; k < count; k++) begin
            if (k > 0) begin
                repeat (6) next_cycle();
            end
            check({name, " din"}, {nv_mem[2*k+1], nv_mem[2*k]}, blk_din);
            check({name, " cpu held off"}, 1'b0, nv_cpu_access);
            blk_buff_addr = blk_buff_addr + 1'b1;
        end
        repeat (6) next_cycle();
        blk_ack = 1'b0;
        wait_cpu_access();
        osd_open      = 1'b0;
        blk_buff_addr = '0;
        next_cycle();
    endtask

    // ==============================
    // Test table and sequencing
    // ==============================
    task automatic build_table();
        add_entry("reset_state", K_RESET, 25'h0, 16'h0, 41'h0);
        add_entry("rom_first", K_ROM, 25'h000000, 16'h1234, {25'h400000, 16'h3412});
        add_entry("rom_mid", K_ROM, 25'h012346, 16'habcd, {25'h412346, 16'hcdab});
        add_entry("rom_odd_masked", K_ROM, 25'h5ffff7, 16'hbeef, {25'h5ffff6, 16'hefbe});
        add_entry("rom_top", K_ROM, 25'h3ffffe, 16'h0f1e, {25'h7ffffe, 16'h1e0f});
        add_entry("rom_overflow", K_OVERFLOW, 25'h000100, 16'h5a3c, {25'h400100, 16'h3c5a});
        add_entry("worm_odd_addr", K_WORM, 25'h000013, 16'ha55a, {25'h0012, 16'ha55a});
        add_entry("worm_masked", K_WORM, 25'h01fffe, 16'h7e81, {25'h1ffe, 16'h7e81});
        add_entry("mount_empty", K_MOUNT_EMPTY, 25'h0, 16'h0, 41'h0);
        add_entry("nv_restore", K_RESTORE, 25'd8, 16'h3c01, 41'h0);
        add_entry("nv_backup", K_BACKUP, 25'd6, 16'h0, 41'h0);
    endtask

    initial begin
        int errors_before;
        rnd            = $urandom(32'hc2a0_8f66);
        cditop_reset   = 1'b1;
        dl_beat        = '0;
        dl_wr          = 1'b0;
        dl_index       = 16'h0000;
        dl_active      = 1'b0;
        sdram_ack      = 1'b0;
        img_mounted    = 1'b0;
        img_size       = 64'd0;
        osd_open       = 1'b0;
        blk_ack        = 1'b0;
        blk_buff_addr  = '0;
        blk_dout       = '0;
        blk_buff_wr    = 1'b0;
        nv_rdata       = '0;
        nv_cpu_changed = 1'b0;
        error_count    = 0;
        pass_count     = 0;
        fail_count     = 0;
        for (int i = 0; i < (1 << `CDI_NVRAM_ADR_W); i++) begin
            rnd       = $urandom;
            nv_mem[i] = rnd[7:0];
        end
        build_table();
        repeat (5) next_cycle();
        cditop_reset = 1'b0;
        next_cycle();
        for (int t = 0; t < name_q.size(); t++) begin
            errors_before = error_count;
            case (kind_q[t])
                K_RESET:       check_reset_state(name_q[t]);
                K_ROM:         run_rom_beat(name_q[t], addr_q[t], data_q[t], exp_q[t]);
                K_OVERFLOW:    run_overflow(name_q[t], addr_q[t], data_q[t], exp_q[t]);
                K_WORM:        run_worm_beat(name_q[t], addr_q[t], data_q[t], exp_q[t]);
                K_MOUNT_EMPTY: run_mount_empty(name_q[t]);
                K_RESTORE:     run_restore(name_q[t], int'(addr_q[t]), data_q[t]);
                K_BACKUP:      run_backup(name_q[t], int'(addr_q[t]));
                default:       check({name_q[t], " kind"}, 1'b0, 1'b1);
            endcase
            // Download session active from here on
            dl_active = 1'b1;
            if (error_count == errors_before) begin
                pass_count++;
                $display("test %s ok", name_q[t]);
            end else begin
                fail_count++;
                $display("test %s failed", name_q[t]);
            end
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
